// File: common/bp_pkg.sv
package bp_pkg;

  // widths
  localparam int xlen = 32;

  // control-transfer opcodes
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // branch target buffer indexed by pc[5:0]
  localparam int btb_index_w = 6;
  localparam int btb_tag_w   = xlen - btb_index_w;

  // local predictor
  localparam int lht_index_w = 4;  // pc[3:0]
  localparam int hist_w      = 4;  // also counter table index
  localparam int ctr_w       = 2;

  // pending branch queue
  localparam int queue_depth = 8;
  localparam int queue_ptr_w = 3;

endpackage

// File: common/bp_update_if.sv
`timescale 1ns/1ps

interface bp_update_if;

  logic                    upd_valid;
  logic [bp_pkg::xlen-1:0] upd_pc;
  logic                    upd_taken;
  logic [bp_pkg::xlen-1:0] upd_target;

  modport source (output upd_valid, output upd_pc, output upd_taken, output upd_target);

  modport btb (input upd_valid, input upd_pc, input upd_taken, input upd_target);

  modport predictor (input upd_valid, input upd_pc, input upd_taken);

endinterface

// File: fetch/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [bp_pkg::xlen-1:0] lookup_pc,
  output logic                    hit,
  output logic [bp_pkg::xlen-1:0] target,
  bp_update_if.btb                upd
);

  logic [2**bp_pkg::btb_index_w-1:0] valid_bits;
  logic [bp_pkg::btb_tag_w-1:0]      tag_mem    [2**bp_pkg::btb_index_w];
  logic [bp_pkg::xlen-1:0]           target_mem [2**bp_pkg::btb_index_w];

  logic [bp_pkg::btb_index_w-1:0] rd_idx;
  logic [bp_pkg::btb_tag_w-1:0]   rd_tag;
  logic [bp_pkg::btb_index_w-1:0] wr_idx;
  logic [bp_pkg::btb_tag_w-1:0]   wr_tag;
  logic                           wr_en;

  assign rd_idx = lookup_pc[bp_pkg::btb_index_w-1:0];
  assign rd_tag = lookup_pc[bp_pkg::xlen-1:bp_pkg::btb_index_w];

  assign wr_idx = upd.upd_pc[bp_pkg::btb_index_w-1:0];
  assign wr_tag = upd.upd_pc[bp_pkg::xlen-1:bp_pkg::btb_index_w];
  assign wr_en  = upd.upd_valid & upd.upd_taken;  // only taken branches allocate

  assign hit    = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = target_mem[rd_idx];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_bits <= '0;
    end
    else if (wr_en)
    begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= upd.upd_target;
    end
  end

endmodule

// File: fetch/local_predictor.sv
`timescale 1ns/1ps

module local_predictor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [bp_pkg::xlen-1:0] lookup_pc,
  output logic                    taken,
  bp_update_if.predictor          upd
);

  logic [bp_pkg::hist_w-1:0] lht [2**bp_pkg::lht_index_w];  // per-pc history
  logic [bp_pkg::ctr_w-1:0]  pht [2**bp_pkg::hist_w];       // 2-bit counters

  logic [bp_pkg::lht_index_w-1:0] rd_idx;
  logic [bp_pkg::hist_w-1:0]      rd_hist;
  logic [bp_pkg::lht_index_w-1:0] upd_idx;
  logic [bp_pkg::hist_w-1:0]      upd_hist;
  logic [bp_pkg::ctr_w-1:0]       upd_ctr;

  assign rd_idx  = lookup_pc[bp_pkg::lht_index_w-1:0];
  assign rd_hist = lht[rd_idx];
  assign taken   = pht[rd_hist][bp_pkg::ctr_w-1];  // msb of counter

  assign upd_idx  = upd.upd_pc[bp_pkg::lht_index_w-1:0];
  assign upd_hist = lht[upd_idx];
  assign upd_ctr  = pht[upd_hist];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**bp_pkg::lht_index_w; i++)
      begin
        lht[i] <= '0;
      end
      for (int j = 0; j < 2**bp_pkg::hist_w; j++)
      begin
        pht[j] <= '0;
      end
    end
    else if (upd.upd_valid)
    begin
      if (upd.upd_taken && (upd_ctr != '1))
        pht[upd_hist] <= upd_ctr + 1'b1;
      else if (!upd.upd_taken && (upd_ctr != '0))
        pht[upd_hist] <= upd_ctr - 1'b1;
      // newest outcome goes in at the top
      lht[upd_idx] <= {upd.upd_taken, upd_hist[bp_pkg::hist_w-1:1]};
    end
  end

endmodule

// File: fetch/branch_queue.sv
`timescale 1ns/1ps

module branch_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  logic [bp_pkg::xlen-1:0] push_pc,
  input  logic                    push_pred_taken,
  input  logic [bp_pkg::xlen-1:0] push_pred_next,
  input  logic                    pop,
  input  logic                    clear,
  output logic                    full,
  output logic                    empty,
  output logic [bp_pkg::xlen-1:0] head_pc,
  output logic                    head_pred_taken,
  output logic [bp_pkg::xlen-1:0] head_pred_next
);

  logic [bp_pkg::xlen-1:0]   pc_mem    [bp_pkg::queue_depth];
  logic                      taken_mem [bp_pkg::queue_depth];
  logic [bp_pkg::xlen-1:0]   next_mem  [bp_pkg::queue_depth];
  logic [bp_pkg::queue_ptr_w-1:0] wptr;
  logic [bp_pkg::queue_ptr_w-1:0] rptr;
  logic [bp_pkg::queue_ptr_w:0]   count;
  logic do_push;
  logic do_pop;

  assign full  = (count == (bp_pkg::queue_ptr_w+1)'(bp_pkg::queue_depth));
  assign empty = (count == '0);

  assign do_push = push & ~full & ~clear;  // clear wins
  assign do_pop  = pop & ~empty & ~clear;

  assign head_pc         = pc_mem[rptr];
  assign head_pred_taken = taken_mem[rptr];
  assign head_pred_next  = next_mem[rptr];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else if (clear)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wptr <= wptr + 1'b1;  // wraps at depth
      if (do_pop)
        rptr <= rptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      pc_mem[wptr]    <= push_pc;
      taken_mem[wptr] <= push_pred_taken;
      next_mem[wptr]  <= push_pred_next;
    end
  end

endmodule

// File: fetch/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [bp_pkg::xlen-1:0] imem_data,
  input  logic                    resolve_valid,
  input  logic                    resolve_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_target,
  input  logic                    btb_hit,
  input  logic [bp_pkg::xlen-1:0] btb_target,
  input  logic                    pred_taken,
  input  logic                    q_full,
  input  logic                    q_empty,
  input  logic [bp_pkg::xlen-1:0] q_head_pc,
  input  logic                    q_head_pred_taken,
  input  logic [bp_pkg::xlen-1:0] q_head_pred_next,
  output logic [bp_pkg::xlen-1:0] imem_addr,
  output logic [bp_pkg::xlen-1:0] lookup_pc,
  output logic                    q_push,
  output logic [bp_pkg::xlen-1:0] q_push_pc,
  output logic                    q_push_pred_taken,
  output logic [bp_pkg::xlen-1:0] q_push_pred_next,
  output logic                    q_pop,
  output logic                    q_clear,
  output logic                    fetch_valid,
  output logic [bp_pkg::xlen-1:0] fetch_pc,
  output logic [bp_pkg::xlen-1:0] fetch_instr,
  output logic                    fetch_pred_taken,
  output logic                    flush,
  output logic                    stall,
  bp_update_if.source             upd
);

  logic [bp_pkg::xlen-1:0] pc;
  logic [6:0]              opcode;
  logic                    is_branch;
  logic                    is_jump;
  logic                    is_ctrl;
  logic                    hold;
  logic                    predict;
  logic [bp_pkg::xlen-1:0] next_pc;
  logic                    res_fire;
  logic                    mispredict;
  logic [bp_pkg::xlen-1:0] correct_pc;

  assign imem_addr = pc;
  assign lookup_pc = pc;

  // opcode classification
  assign opcode    = imem_data[6:0];
  assign is_branch = (opcode == bp_pkg::op_branch);
  assign is_jump   = (opcode == bp_pkg::op_jal) || (opcode == bp_pkg::op_jalr);
  assign is_ctrl   = is_branch | is_jump;

  assign predict = (is_jump & btb_hit) | (is_branch & btb_hit & pred_taken);
  assign next_pc = predict ? btb_target : pc + 1'b1;
  assign hold    = is_ctrl & q_full;  // no room to track it

  assign q_push            = is_ctrl & ~q_full;
  assign q_push_pc         = pc;
  assign q_push_pred_taken = predict;
  assign q_push_pred_next  = next_pc;

  // resolve against oldest pending branch
  assign res_fire   = resolve_valid & ~q_empty;
  assign mispredict = res_fire &&
                      ((resolve_taken != q_head_pred_taken) ||
                       (resolve_taken && (resolve_target != q_head_pred_next)));
  assign correct_pc = resolve_taken ? resolve_target : q_head_pc + 1'b1;

  assign q_pop   = res_fire;
  assign q_clear = mispredict;
  assign stall   = q_full;

  assign upd.upd_valid  = res_fire;
  assign upd.upd_pc     = q_head_pc;
  assign upd.upd_taken  = resolve_taken;
  assign upd.upd_target = resolve_target;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc          <= '0;
      fetch_valid <= 1'b0;
      flush       <= 1'b0;
    end
    else
    begin
      if (mispredict)
        pc <= correct_pc;  // redirect
      else if (!hold)
        pc <= next_pc;
      fetch_valid <= ~mispredict & ~hold;
      flush       <= mispredict;
    end
  end

  always_ff @(posedge clk)
  begin
    fetch_pc         <= pc;
    fetch_instr      <= imem_data;
    fetch_pred_taken <= predict;
  end

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [bp_pkg::xlen-1:0] imem_data,
  input  logic                    resolve_valid,
  input  logic                    resolve_taken,
  input  logic [bp_pkg::xlen-1:0] resolve_target,
  output logic [bp_pkg::xlen-1:0] imem_addr,
  output logic                    fetch_valid,
  output logic [bp_pkg::xlen-1:0] fetch_pc,
  output logic [bp_pkg::xlen-1:0] fetch_instr,
  output logic                    fetch_pred_taken,
  output logic                    flush,
  output logic                    stall
);

  logic [bp_pkg::xlen-1:0] lookup_pc;
  logic                    btb_hit;
  logic [bp_pkg::xlen-1:0] btb_target;
  logic                    pred_taken;
  logic                    q_push;
  logic [bp_pkg::xlen-1:0] q_push_pc;
  logic                    q_push_pred_taken;
  logic [bp_pkg::xlen-1:0] q_push_pred_next;
  logic                    q_pop;
  logic                    q_clear;
  logic                    q_full;
  logic                    q_empty;
  logic [bp_pkg::xlen-1:0] q_head_pc;
  logic                    q_head_pred_taken;
  logic [bp_pkg::xlen-1:0] q_head_pred_next;

  bp_update_if upd_bus ();  // resolve updates

  fetch_sequencer u_seq (
    .clk               (clk),
    .rst               (rst),
    .imem_data         (imem_data),
    .resolve_valid     (resolve_valid),
    .resolve_taken     (resolve_taken),
    .resolve_target    (resolve_target),
    .btb_hit           (btb_hit),
    .btb_target        (btb_target),
    .pred_taken        (pred_taken),
    .q_full            (q_full),
    .q_empty           (q_empty),
    .q_head_pc         (q_head_pc),
    .q_head_pred_taken (q_head_pred_taken),
    .q_head_pred_next  (q_head_pred_next),
    .imem_addr         (imem_addr),
    .lookup_pc         (lookup_pc),
    .q_push            (q_push),
    .q_push_pc         (q_push_pc),
    .q_push_pred_taken (q_push_pred_taken),
    .q_push_pred_next  (q_push_pred_next),
    .q_pop             (q_pop),
    .q_clear           (q_clear),
    .fetch_valid       (fetch_valid),
    .fetch_pc          (fetch_pc),
    .fetch_instr       (fetch_instr),
    .fetch_pred_taken  (fetch_pred_taken),
    .flush             (flush),
    .stall             (stall),
    .upd               (upd_bus.source)
  );

  branch_target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .lookup_pc (lookup_pc),
    .hit       (btb_hit),
    .target    (btb_target),
    .upd       (upd_bus.btb)
  );

  local_predictor u_pred (
    .clk       (clk),
    .rst       (rst),
    .lookup_pc (lookup_pc),
    .taken     (pred_taken),
    .upd       (upd_bus.predictor)
  );

  branch_queue u_queue (
    .clk             (clk),
    .rst             (rst),
    .push            (q_push),
    .push_pc         (q_push_pc),
    .push_pred_taken (q_push_pred_taken),
    .push_pred_next  (q_push_pred_next),
    .pop             (q_pop),
    .clear           (q_clear),
    .full            (q_full),
    .empty           (q_empty),
    .head_pc         (q_head_pc),
    .head_pred_taken (q_head_pred_taken),
    .head_pred_next  (q_head_pred_next)
  );

endmodule

// File: testbench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

  logic                    clk;
  logic                    rst;
  logic [bp_pkg::xlen-1:0] imem_data;
  logic                    resolve_valid;
  logic                    resolve_taken;
  logic [bp_pkg::xlen-1:0] resolve_target;
  logic [bp_pkg::xlen-1:0] imem_addr;
  logic                    fetch_valid;
  logic [bp_pkg::xlen-1:0] fetch_pc;
  logic [bp_pkg::xlen-1:0] fetch_instr;
  logic                    fetch_pred_taken;
  logic                    flush;
  logic                    stall;

  // test table with one entry per row
  string       row_name    [$];
  logic [31:0] row_pc      [$];
  logic [6:0]  row_op      [$];
  int          row_idle    [$];
  logic        row_taken   [$];
  logic [31:0] row_target  [$];
  int          row_further [$];

  bit          placed      [64];
  logic [31:0] prog_mem    [64];
  logic        prog_taken  [64];  // usual outcome of each placed branch
  logic [31:0] prog_target [64];

  // reference predictor state
  logic                         m_valid  [2**bp_pkg::btb_index_w];
  logic [bp_pkg::btb_tag_w-1:0] m_tag    [2**bp_pkg::btb_index_w];
  logic [31:0]                  m_target [2**bp_pkg::btb_index_w];
  logic [bp_pkg::hist_w-1:0]    m_hist   [2**bp_pkg::lht_index_w];
  logic [bp_pkg::ctr_w-1:0]     m_ctr    [2**bp_pkg::hist_w];
  logic [31:0]                  m_pc;
  logic [31:0]                  q_pc     [$];
  logic                         q_pred   [$];
  logic [31:0]                  q_next   [$];
  logic                         exp_valid;
  logic                         exp_hold;
  logic                         exp_flush;
  logic                         exp_pred;
  logic [31:0]                  exp_pc;
  logic [31:0]                  exp_instr;

  int     errors = 0;
  int     checks = 0;
  integer seed;
  bit     table_ready = 1'b0;

  fetch_top UUT (
    .clk              (clk),
    .rst              (rst),
    .imem_data        (imem_data),
    .resolve_valid    (resolve_valid),
    .resolve_taken    (resolve_taken),
    .resolve_target   (resolve_target),
    .imem_addr        (imem_addr),
    .fetch_valid      (fetch_valid),
    .fetch_pc         (fetch_pc),
    .fetch_instr      (fetch_instr),
    .fetch_pred_taken (fetch_pred_taken),
    .flush            (flush),
    .stall            (stall)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] tb_word(input logic [31:0] addr);
    if (addr < 64 && placed[addr[5:0]])
      return prog_mem[addr[5:0]];
    return {addr[24:0] ^ {18'b0, addr[31:25]}, 7'h13};  // addi opcode so never a branch
  endfunction

  always_comb imem_data = tb_word(imem_addr);

  task add_row(input string name, input logic [31:0] pc, input logic [6:0] op, input int idle,
               input logic taken, input logic [31:0] target, input int further);
    row_name.push_back(name);
    row_pc.push_back(pc);
    row_op.push_back(op);
    row_idle.push_back(idle);
    row_taken.push_back(taken);
    row_target.push_back(target);
    row_further.push_back(further);
  endtask

  // first row naming a pc sets its word and usual outcome
  task place_program();
    for (int i = 0; i < row_pc.size(); i++)
    begin
      if (!placed[row_pc[i][5:0]])
      begin
        placed[row_pc[i][5:0]]      = 1'b1;
        prog_mem[row_pc[i][5:0]]    = {row_pc[i][24:0], row_op[i]};
        prog_taken[row_pc[i][5:0]]  = row_taken[i];
        prog_target[row_pc[i][5:0]] = row_target[i];
      end
    end
  endtask

  task check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want)
    else
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task reset_model();
    m_pc      = '0;
    exp_valid = 1'b0;
    exp_hold  = 1'b0;
    exp_flush = 1'b0;
    q_pc.delete();
    q_pred.delete();
    q_next.delete();
    foreach (m_valid[i])
      m_valid[i] = 1'b0;
    foreach (m_hist[i])
      m_hist[i] = '0;
    foreach (m_ctr[i])
      m_ctr[i] = '0;
  endtask

  task train_model(input logic [31:0] pc, input logic taken, input logic [31:0] target);
    logic [bp_pkg::hist_w-1:0] h;
    h = m_hist[pc[bp_pkg::lht_index_w-1:0]];
    if (taken)
    begin
      m_valid[pc[bp_pkg::btb_index_w-1:0]]  = 1'b1;
      m_tag[pc[bp_pkg::btb_index_w-1:0]]    = pc[bp_pkg::xlen-1:bp_pkg::btb_index_w];
      m_target[pc[bp_pkg::btb_index_w-1:0]] = target;
    end
    if (taken && m_ctr[h] != 2'b11)
      m_ctr[h] = m_ctr[h] + 1'b1;  // saturating
    else if (!taken && m_ctr[h] != 2'b00)
      m_ctr[h] = m_ctr[h] - 1'b1;
    m_hist[pc[bp_pkg::lht_index_w-1:0]] = {taken, h[bp_pkg::hist_w-1:1]};
  endtask

  // one model step per cycle ahead of the coming edge
  always @(negedge clk)
  begin
    logic [31:0]                    word;
    logic [bp_pkg::btb_index_w-1:0] bi;
    logic                           is_ctrl;
    logic                           predict;
    logic                           full;
    logic                           res;
    logic                           mis;
    logic [31:0]                    next;
    logic [31:0]                    fix_pc;
    if (rst)
      reset_model();
    check_value("fetch_valid", fetch_valid, exp_valid);
    check_value("flush", flush, exp_flush);
    check_value("stall", stall, q_pc.size() == bp_pkg::queue_depth);
    check_value("imem_addr", imem_addr, m_pc);
    if (exp_valid)
    begin
      check_value("fetch_pc", fetch_pc, exp_pc);
      check_value("fetch_instr", fetch_instr, exp_instr);
      check_value("fetch_pred_taken", fetch_pred_taken, exp_pred);
    end
    else if (exp_hold)
      check_value("held fetch_pc", fetch_pc, exp_pc);
    if (!rst)
    begin
      word    = tb_word(m_pc);
      bi      = m_pc[bp_pkg::btb_index_w-1:0];
      is_ctrl = word[6:0] == bp_pkg::op_branch || word[6:0] == bp_pkg::op_jal ||
                word[6:0] == bp_pkg::op_jalr;
      predict = is_ctrl && m_valid[bi] &&
                m_tag[bi] == m_pc[bp_pkg::xlen-1:bp_pkg::btb_index_w] &&
                (word[6:0] != bp_pkg::op_branch ||
                 m_ctr[m_hist[m_pc[bp_pkg::lht_index_w-1:0]]][bp_pkg::ctr_w-1]);
      next    = predict ? m_target[bi] : m_pc + 1;
      full    = q_pc.size() == bp_pkg::queue_depth;
      res     = resolve_valid && q_pc.size() > 0;
      mis     = res && (resolve_taken != q_pred[0] ||
                        (resolve_taken && resolve_target != q_next[0]));
      exp_pc    = m_pc;
      exp_instr = word;
      exp_pred  = predict;
      exp_hold  = !mis && is_ctrl && full;
      exp_valid = !mis && !(is_ctrl && full);
      exp_flush = mis;
      if (res)
      begin
        fix_pc = resolve_taken ? resolve_target : q_pc[0] + 1;
        train_model(q_pc[0], resolve_taken, resolve_target);
      end
      if (mis)
      begin
        q_pc.delete();
        q_pred.delete();
        q_next.delete();
        m_pc = fix_pc;
      end
      else
      begin
        if (res)
        begin
          void'(q_pc.pop_front());
          void'(q_pred.pop_front());
          void'(q_next.pop_front());
        end
        if (is_ctrl && !full)
        begin
          q_pc.push_back(m_pc);
          q_pred.push_back(predict);
          q_next.push_back(next);
        end
        if (!(is_ctrl && full))
          m_pc = next;
      end
    end
  end

  task send_resolve(input logic taken, input logic [31:0] target);
    resolve_valid  <= 1'b1;
    resolve_taken  <= taken;
    resolve_target <= target;
    @(posedge clk);
    resolve_valid  <= 1'b0;
  endtask

  initial
  begin
    int gap;
    int first_err;
    seed           = 32'hc589;
    rst            = 1'b1;
    resolve_valid  = 1'b0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    add_row("cold_branch",      4,  bp_pkg::op_branch, 1, 1'b1, 8, 0);
    add_row("jal_cold",         12, bp_pkg::op_jal,    1, 1'b1, 4, 0);
    add_row("jal_hit",          12, bp_pkg::op_jal,    2, 1'b1, 4, 0);
    for (int i = 0; i < 5; i++)
      add_row("train_branch",   4,  bp_pkg::op_branch, i % 4, 1'b1, 8, 0);
    add_row("branch_not_taken", 4,  bp_pkg::op_branch, 1, 1'b0, 0, 0);
    for (int i = 0; i < 4; i++)
      add_row("retrain_branch", 4,  bp_pkg::op_branch, 1, 1'b1, 8, 0);
    add_row("queue_full",       4,  bp_pkg::op_branch, 2, 1'b1, 8, bp_pkg::queue_depth);
    add_row("jal_after_stall",  12, bp_pkg::op_jal,    1, 1'b1, 4, 0);
    place_program();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < row_pc.size(); t++)
    begin
      first_err = errors;
      // older branches resolve with their usual outcome
      while (q_pc.size() == 0 || q_pc[0] != row_pc[t])
      begin
        if (q_pc.size() == 0)
          @(posedge clk);
        else
          send_resolve(prog_taken[q_pc[0][5:0]], prog_target[q_pc[0][5:0]]);
      end
      while (q_pc.size() < row_further[t])
        @(posedge clk);
      gap = row_idle[t] + int'($unsigned($random(seed)) % 3);
      repeat (gap) @(posedge clk);
      send_resolve(row_taken[t], row_target[t]);
      repeat (3) @(posedge clk);  // let the redirect show
      $display("test %0d %s: %s", t + 1, row_name[t], (errors == first_err) ? "ok" : "FAILED");
    end
    $display("%0d tests, %0d checks, %0d errors", row_pc.size(), checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial
  begin
    int budget;
    wait (table_ready);
    budget = 16 + 200;  // reset plus margin
    foreach (row_idle[i])
      budget += row_idle[i] + 3 + row_further[i] * 12 + 80;
    #(budget * 4);
    $display("watchdog expired after %0d cycles, the tests did not finish", budget);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: filelist.f
common/bp_pkg.sv
common/bp_update_if.sv
fetch/branch_target_buffer.sv
fetch/local_predictor.sv
fetch/branch_queue.sv
fetch/fetch_sequencer.sv
hw/fetch_top.sv
testbench/tb_fetch.sv

// File: Makefile
# Verilator flow for the fetch front end

VERILATOR ?= verilator
FILELIST  ?= filelist.f
RTL_TOP   ?= fetch_top
TB_TOP    ?= tb_fetch
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_MSG  ?= Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# pass only if the testbench printed the pass line
sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
